/* testbench/spi_gpu_patterns.txt */
# T n b0 .. : one transaction of n bytes (hex) | P addr pixel : framebuffer write
# L entry rgb : palette write | S flag : status reply | E flag : output_enabled level
# status read before any enable
T 3 40 00 00
S 0
# four pixels from 0x00100
T 8 82 00 01 00 a5 3c 7e 01
P 00100 a5
P 00101 3c
P 00102 7e
P 00103 01
# address bits above bit 16 are dropped
T 6 82 fe 00 20 5a c3
P 00020 5a
P 00021 c3
# wrap from 76799 to 0
T 7 82 01 2b fe 11 22 33
P 12bfe 11
P 12bff 22
P 00000 33
# two palette entries, trailing byte gives no write
T 8 83 11 22 33 44 55 66 77
L 00 112233
L 01 445566
# a new palette set starts at entry 0 again
T 4 83 aa bb cc
L 00 aabbcc
# enable, status, disable, status
T 1 01
E 1
T 3 40 00 00
S 1
T 1 00
E 0
T 3 40 00 00
S 0
# unknown command with payload
T 4 c5 12 34 56
E 0

/* verilog.f */
+incdir+source
source/spi_gpu_pkg.sv
source/byte_stream_if.sv
source/spi_nibble_rx.sv
source/gpu_command_decoder.sv
source/word_assembler.sv
source/spi_reply_tx.sv
source/spi_gpu_top.sv
testbench/spi_gpu_asserts.sv
testbench/spi_gpu_tb.sv

/* testbench/spi_gpu_tb.sv */
`timescale 1ns/1ns

`include "spi_gpu_settings.svh"

module spi_gpu_tb
    import spi_gpu_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int MIN_GAP      = 6;      // idle cycles after cs_n rises
    localparam int MAX_GAP      = MIN_GAP + 7;
    localparam int WAIT_LIMIT   = 8;      // cycles to wait for a late result

    logic           sclk = 1'b0;
    logic           reset = 1'b1;
    logic           cs_n = 1'b1;
    nibble_t        data_in = '0;
    logic           hblank = 1'b0;
    logic           vblank = 1'b0;
    nibble_t        data_out;
    logic           data_oe;
    logic           fb_rgb_wren;
    fb_addr_t       fb_rgb_addr;
    pixel_t         fb_rgb_data;
    logic           fb_palette_wren;
    palette_addr_t  fb_palette_addr;
    palette_entry_t fb_palette_data;
    logic           output_enabled;

    // parsed pattern file
    byte   kind_q[$];
    int    arg_q[$];
    int    val_q[$];
    byte_t stim_q[$];

    // observed results
    fb_addr_t       pix_addr_q[$];
    pixel_t         pix_data_q[$];
    palette_addr_t  pal_addr_q[$];
    palette_entry_t pal_data_q[$];
    int             reply_slot_q[$];
    nibble_t        reply_nib_q[$];

    int   slot = 0;                 // nibble slot since cs_n fell
    int   checks = 0;
    int   value_errors = 0;
    int   other_errors = 0;
    int   assert_errors = 0;
    int   limit_cycles = 0;
    int   cycle_count = 0;
    logic tx_hblank;                // levels held during the last transaction
    logic tx_vblank;

    spi_gpu_top spi_gpu_top_i (.*);

    always #5 sclk = ~sclk;

    always @(posedge sclk)
    begin
        if (!reset && fb_rgb_wren)
        begin
            pix_addr_q.push_back(fb_rgb_addr);
            pix_data_q.push_back(fb_rgb_data);
        end
        if (!reset && fb_palette_wren)
        begin
            pal_addr_q.push_back(fb_palette_addr);
            pal_data_q.push_back(fb_palette_data);
        end
        if (!reset && data_oe)
        begin
            reply_slot_q.push_back(slot);
            reply_nib_q.push_back(data_out);
        end
        slot <= cs_n ? 0 : slot + 1;
    end

    task automatic read_patterns();
        int    fd;
        int    n;
        int    k;
        int    a;
        int    v;
        string tok;
        string rest;
        fd = $fopen("testbench/spi_gpu_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open the pattern file");
            other_errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1)
        begin
            a = 0;
            v = 0;
            if (tok[0] == "#")
                void'($fgets(rest, fd));   // comment line
            else if (tok == "T")
            begin
                void'($fscanf(fd, "%d", a));
                for (k = 0; k < a; k++)
                begin
                    void'($fscanf(fd, "%h", n));
                    stim_q.push_back(byte_t'(n));
                end
            end
            else if (tok == "P" || tok == "L")
                void'($fscanf(fd, "%h %h", a, v));
            else if (tok == "S" || tok == "E")
                void'($fscanf(fd, "%h", a));
            else
            begin
                $display("error: unknown line kind %s in the pattern file", tok);
                other_errors++;
                void'($fgets(rest, fd));
            end
            if (tok == "T" || tok == "P" || tok == "L" || tok == "S" || tok == "E")
            begin
                kind_q.push_back(tok[0]);
                arg_q.push_back(a);
                val_q.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // every transaction and every wait counted at its worst case, then doubled
    function automatic int run_length();
        int total;
        int i;
        total = RESET_CYCLES;
        for (i = 0; i < kind_q.size(); i++)
            total += (kind_q[i] == "T") ? 2 * arg_q[i] + 2 + MAX_GAP : WAIT_LIMIT;
        return 2 * total;
    endfunction

    task automatic send_transaction(input int n);
        int    k;
        int    gap;
        byte_t b;
        hblank    = 1'($urandom % 2);
        vblank    = 1'($urandom % 2);
        tx_hblank = hblank;
        tx_vblank = vblank;
        cs_n      = 1'b0;
        for (k = 0; k < n; k++)
        begin
            b       = stim_q.pop_front();
            data_in = b[7:4];   // high nibble first
            @(negedge sclk);
            data_in = b[3:0];
            @(negedge sclk);
        end
        cs_n    = 1'b1;
        data_in = '0;
        gap     = MIN_GAP + int'($urandom % 8);
        repeat (gap) @(negedge sclk);
    endtask

    task automatic check_pixel_write(input fb_addr_t got_addr, input pixel_t got_data,
                                     input fb_addr_t exp_addr, input pixel_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data)
        begin
            value_errors++;
            $display("[FAIL] %0t ns: pixel write %05h <= %02h, expected %05h <= %02h",
                     $time, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_palette_write(input palette_addr_t got_addr,
                                       input palette_entry_t got_data,
                                       input palette_addr_t exp_addr,
                                       input palette_entry_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data)
        begin
            value_errors++;
            $display("[FAIL] %0t ns: palette write %02h <= %06h, expected %02h <= %06h",
                     $time, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t ns: status byte %08b, expected %08b", $time, got, exp);
        end
    endtask

    task automatic check_enable(input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t ns: output_enabled %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic expect_pixel(input fb_addr_t exp_addr, input pixel_t exp_data);
        int waited;
        waited = 0;
        while (pix_addr_q.size() == 0 && waited < WAIT_LIMIT)
        begin
            @(negedge sclk);
            waited++;
        end
        if (pix_addr_q.size() == 0)
        begin
            $display("error at %0t ns: no pixel write for address %05h", $time, exp_addr);
            other_errors++;
        end
        else
            check_pixel_write(pix_addr_q.pop_front(), pix_data_q.pop_front(),
                              exp_addr, exp_data);
    endtask

    task automatic expect_palette(input palette_addr_t exp_addr,
                                  input palette_entry_t exp_data);
        int waited;
        waited = 0;
        while (pal_addr_q.size() == 0 && waited < WAIT_LIMIT)
        begin
            @(negedge sclk);
            waited++;
        end
        if (pal_addr_q.size() == 0)
        begin
            $display("error at %0t ns: no palette write for entry %02h", $time, exp_addr);
            other_errors++;
        end
        else
            check_palette_write(pal_addr_q.pop_front(), pal_data_q.pop_front(),
                                exp_addr, exp_data);
    endtask

    task automatic expect_status(input logic flag);
        status_t exp;
        status_t got;
        int      slot_hi;
        int      slot_lo;
        int      waited;
        waited = 0;
        while (reply_nib_q.size() < 2 && waited < WAIT_LIMIT)
        begin
            @(negedge sclk);
            waited++;
        end
        if (reply_nib_q.size() < 2)
        begin
            $display("error at %0t ns: status reply missing or cut short", $time);
            other_errors++;
            return;
        end
        slot_hi     = reply_slot_q.pop_front();
        slot_lo     = reply_slot_q.pop_front();
        got[7:4]    = reply_nib_q.pop_front();
        got[3:0]    = reply_nib_q.pop_front();
        if (slot_hi != 4 || slot_lo != 5)
        begin
            $display("error at %0t ns: status reply driven in slots %0d and %0d, not 4 and 5",
                     $time, slot_hi, slot_lo);
            other_errors++;
        end
        exp.id             = `SPI_GPU_STATUS_ID;
        exp.hblank         = tx_hblank;
        exp.vblank         = tx_vblank;
        exp.output_enabled = flag;
        check_status(got, exp);
    endtask

    // anything still queued was not asked for by the patterns
    task automatic check_leftovers();
        if (pix_addr_q.size() != 0)
        begin
            $display("error at %0t ns: %0d unexpected pixel writes", $time, pix_addr_q.size());
            other_errors++;
            pix_addr_q.delete();
            pix_data_q.delete();
        end
        if (pal_addr_q.size() != 0)
        begin
            $display("error at %0t ns: %0d unexpected palette writes", $time, pal_addr_q.size());
            other_errors++;
            pal_addr_q.delete();
            pal_data_q.delete();
        end
        if (reply_nib_q.size() != 0)
        begin
            $display("error at %0t ns: %0d unexpected reply nibbles", $time, reply_nib_q.size());
            other_errors++;
            reply_slot_q.delete();
            reply_nib_q.delete();
        end
    endtask

    initial
    begin : watchdog
        wait (limit_cycles > 0);
        while (cycle_count < limit_cycles)
        begin
            @(posedge sclk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin : main
        int i;
        void'($urandom(39187));
        read_patterns();
        limit_cycles = run_length();
        repeat (RESET_CYCLES) @(negedge sclk);
        reset = 1'b0;
        @(negedge sclk);
        for (i = 0; i < kind_q.size(); i++)
        begin
            case (kind_q[i])
                "T" :
                begin
                    check_leftovers();
                    send_transaction(arg_q[i]);
                end
                "P" : expect_pixel(fb_addr_t'(arg_q[i]), pixel_t'(val_q[i]));
                "L" : expect_palette(palette_addr_t'(arg_q[i]), palette_entry_t'(val_q[i][23:0]));
                "S" : expect_status(arg_q[i][0]);
                "E" : check_enable(output_enabled, arg_q[i][0]);
                default : ;
            endcase
        end
        check_leftovers();
        if (checks == 0)
        begin
            $display("error: no checks were run");
            other_errors++;
        end
        assert_errors = spi_gpu_top_i.asserts_i.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* testbench/spi_gpu_asserts.sv */
`timescale 1ns/1ns

`include "spi_gpu_settings.svh"

// protocol checks on the top level ports
module spi_gpu_asserts
    import spi_gpu_pkg::*;
(
    input logic     sclk,
    input logic     reset,
    input logic     cs_n,
    input logic     data_oe,
    input logic     fb_rgb_wren,
    input logic     fb_palette_wren,
    input fb_addr_t fb_rgb_addr
);

    int fail_count = 0;   // failed assertions so far

    // no reply nibble while deselected or on the first slot after reselection
    oe_only_when_selected : assert property (@(posedge sclk) disable iff (reset)
        cs_n |-> !data_oe ##1 !data_oe)
        else
        begin
            $error("data_oe high while cs_n is high or right after it");
            fail_count++;
        end

    no_write_in_reset : assert property (@(posedge sclk)
        reset |=> !fb_rgb_wren && !fb_palette_wren)
        else
        begin
            $error("write enable high during reset");
            fail_count++;
        end

    fb_addr_in_range : assert property (@(posedge sclk) disable iff (reset)
        fb_rgb_wren |-> fb_rgb_addr < `SPI_GPU_FB_PIXELS)
        else
        begin
            $error("framebuffer write beyond the last pixel");
            fail_count++;
        end

    // one reply byte is two nibble slots
    oe_two_cycles_max : assert property (@(posedge sclk) disable iff (reset)
        data_oe [*2] |=> !data_oe)
        else
        begin
            $error("data_oe high for more than two cycles");
            fail_count++;
        end

endmodule

bind spi_gpu_top spi_gpu_asserts asserts_i (
    .sclk            (sclk),
    .reset           (reset),
    .cs_n            (cs_n),
    .data_oe         (data_oe),
    .fb_rgb_wren     (fb_rgb_wren),
    .fb_palette_wren (fb_palette_wren),
    .fb_rgb_addr     (fb_rgb_addr)
);

/* source/spi_gpu_top.sv */
`timescale 1ns/1ns

module spi_gpu_top
    import spi_gpu_pkg::*;
(
    input  logic           sclk,
    input  logic           reset,
    input  logic           cs_n,
    input  nibble_t        data_in,
    output nibble_t        data_out,
    output logic           data_oe,
    input  logic           hblank,
    input  logic           vblank,
    output logic           fb_rgb_wren,
    output fb_addr_t       fb_rgb_addr,
    output pixel_t         fb_rgb_data,
    output logic           fb_palette_wren,
    output palette_addr_t  fb_palette_addr,
    output palette_entry_t fb_palette_data,
    output logic           output_enabled
);

`include "spi_gpu_settings.svh"

    byte_stream_if rx_bytes ();
    byte_stream_if fb_bytes ();
    byte_stream_if pal_bytes ();

    logic  reply_load;
    byte_t reply_byte;

    spi_nibble_rx nibble_rx_i (
        .sclk    (sclk),
        .reset   (reset),
        .cs_n    (cs_n),
        .data_in (data_in),
        .bytes   (rx_bytes)
    );

    gpu_command_decoder decoder_i (
        .sclk           (sclk),
        .reset          (reset),
        .hblank         (hblank),
        .vblank         (vblank),
        .rx             (rx_bytes),
        .fb             (fb_bytes),
        .pal            (pal_bytes),
        .reply_load     (reply_load),
        .reply_byte     (reply_byte),
        .output_enabled (output_enabled)
    );

    // pixel writer, 3-byte start address then one byte per pixel
    word_assembler #(
        .word_t     (pixel_t),
        .addr_t     (fb_addr_t),
        .ADDR_BYTES (`SPI_GPU_FB_ADDR_BYTES),
        .ADDR_LIMIT (`SPI_GPU_FB_PIXELS)
    ) pixel_writer_i (
        .sclk  (sclk),
        .reset (reset),
        .bytes (fb_bytes),
        .wren  (fb_rgb_wren),
        .addr  (fb_rgb_addr),
        .wdata (fb_rgb_data)
    );

    word_assembler #(
        .word_t     (palette_entry_t),
        .addr_t     (palette_addr_t),
        .ADDR_BYTES (0),                           // always starts at entry 0
        .ADDR_LIMIT (`SPI_GPU_PALETTE_ENTRIES)
    ) palette_writer_i (
        .sclk  (sclk),
        .reset (reset),
        .bytes (pal_bytes),
        .wren  (fb_palette_wren),
        .addr  (fb_palette_addr),
        .wdata (fb_palette_data)
    );

    spi_reply_tx reply_tx_i (
        .sclk       (sclk),
        .reset      (reset),
        .cs_n       (cs_n),
        .reply_load (reply_load),
        .reply_byte (reply_byte),
        .data_out   (data_out),
        .data_oe    (data_oe)
    );

endmodule

/* source/spi_reply_tx.sv */
`timescale 1ns/1ns

module spi_reply_tx
    import spi_gpu_pkg::*;
(
    input  logic    sclk,
    input  logic    reset,
    input  logic    cs_n,
    input  logic    reply_load,
    input  byte_t   reply_byte,
    output nibble_t data_out,
    output logic    data_oe
);

`include "spi_gpu_settings.svh"

    // the decoder and this stage each take up one dummy slot
    localparam int WAIT_SLOTS = `SPI_GPU_DUMMY_SLOTS - 2;

    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_DUMMY,
        TX_HI,
        TX_LO
    } tx_state_t;

    tx_state_t  state;
    logic [3:0] wait_cnt;
    byte_t      held;

    always_ff @(posedge sclk)
    begin
        if (reset || cs_n)   // end of transaction aborts the reply
        begin
            state    <= TX_IDLE;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE :
                begin
                    if (reply_load)
                    begin
                        state    <= (WAIT_SLOTS == 0) ? TX_HI : TX_DUMMY;
                        wait_cnt <= 4'(WAIT_SLOTS);
                    end
                end
                TX_DUMMY :
                begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt == 4'd1)
                        state <= TX_HI;
                end
                TX_HI   : state <= TX_LO;
                default : state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sclk)
    begin
        if (reply_load)
            held <= reply_byte;
    end

    assign data_out = (state == TX_LO) ? held[3:0] : held[7:4];
    assign data_oe  = (state == TX_HI || state == TX_LO) && !cs_n;   // release the bus at once

endmodule

/* source/word_assembler.sv */
`timescale 1ns/1ns

module word_assembler
    import spi_gpu_pkg::*;
#(
    parameter type word_t     = byte_t,
    parameter type addr_t     = logic [7:0],
    parameter int  ADDR_BYTES = 0,     // start address header length, 0 starts at 0
    parameter int  ADDR_LIMIT = 256    // address wraps here
)
(
    input  logic        sclk,
    input  logic        reset,
    byte_stream_if.sink bytes,
    output logic        wren,
    output addr_t       addr,
    output word_t       wdata
);

    localparam int    WORD_W     = $bits(word_t);
    localparam int    ADDR_W     = $bits(addr_t);
    localparam int    WORD_BYTES = WORD_W / 8;
    localparam int    CNT_W      = $clog2(ADDR_BYTES + WORD_BYTES + 1);
    localparam addr_t LAST_ADDR  = addr_t'(ADDR_LIMIT - 1);

    logic [CNT_W-1:0]  hdr_left;    // header bytes still expected
    logic [CNT_W-1:0]  byte_cnt;    // bytes of the current word already shifted in
    addr_t             next_addr;
    logic [WORD_W-1:0] word_sr;

    logic [CNT_W-1:0]  hdr_rem;
    logic [CNT_W-1:0]  byte_idx;
    addr_t             cur_addr;
    logic [ADDR_W+7:0] addr_shift;
    logic [WORD_W+7:0] word_shift;
    logic              in_header;
    logic              word_done;

    // the first payload byte restarts header, word and address
    assign hdr_rem    = bytes.first ? CNT_W'(ADDR_BYTES) : hdr_left;
    assign byte_idx   = bytes.first ? '0 : byte_cnt;
    assign cur_addr   = bytes.first ? '0 : next_addr;
    assign addr_shift = {cur_addr, bytes.data};   // excess header bits fall off the top
    assign word_shift = {word_sr, bytes.data};
    assign in_header  = hdr_rem != '0;
    assign word_done  = !in_header && (byte_idx == CNT_W'(WORD_BYTES - 1));

    always_ff @(posedge sclk)
    begin
        if (reset || bytes.frame_end)
        begin
            hdr_left  <= CNT_W'(ADDR_BYTES);
            byte_cnt  <= '0;
            next_addr <= '0;
            wren      <= 1'b0;
        end
        else
        begin
            wren <= 1'b0;
            if (bytes.valid)
            begin
                if (in_header)
                begin
                    hdr_left  <= hdr_rem - 1'b1;
                    byte_cnt  <= '0;
                    next_addr <= addr_t'(addr_shift[ADDR_W-1:0]);
                end
                else if (word_done)
                begin
                    wren     <= 1'b1;
                    byte_cnt <= '0;
                    // wrap at the end of the memory
                    next_addr <= (cur_addr >= LAST_ADDR) ? '0 : addr_t'(cur_addr + 1'b1);
                end
                else
                    byte_cnt <= byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        if (bytes.valid && !in_header)
            word_sr <= word_shift[WORD_W-1:0];   // msb first
        if (bytes.valid && word_done)
        begin
            addr  <= cur_addr;
            wdata <= word_t'(word_shift[WORD_W-1:0]);
        end
    end

endmodule

/* source/gpu_command_decoder.sv */
`timescale 1ns/1ns

module gpu_command_decoder
    import spi_gpu_pkg::*;
(
    input  logic          sclk,
    input  logic          reset,
    input  logic          hblank,
    input  logic          vblank,
    byte_stream_if.sink   rx,
    byte_stream_if.source fb,
    byte_stream_if.source pal,
    output logic          reply_load,
    output byte_t         reply_byte,
    output logic          output_enabled
);

`include "spi_gpu_settings.svh"

    opcode_t opcode;          // command of the current transaction
    logic    opcode_ok;       // known command latched
    logic    payload_first;   // next payload byte is the first one

    opcode_t rx_op;
    logic    rx_op_known;
    status_t status_now;

    assign rx_op = opcode_t'(rx.data);

    // anything outside the five kept commands is ignored
    assign rx_op_known = rx.data inside {OP_FB_WRITE, OP_PALETTE_SET, OP_READ_STATUS,
                                         OP_ENABLE, OP_DISABLE};

    always_comb
    begin
        status_now.id             = `SPI_GPU_STATUS_ID;
        status_now.hblank         = hblank;
        status_now.vblank         = vblank;
        status_now.output_enabled = output_enabled;
    end

    always_ff @(posedge sclk)
    begin
        if (reset)
        begin
            opcode_ok      <= 1'b0;
            payload_first  <= 1'b0;
            fb.valid       <= 1'b0;
            fb.first       <= 1'b0;
            fb.frame_end   <= 1'b0;
            pal.valid      <= 1'b0;
            pal.first      <= 1'b0;
            pal.frame_end  <= 1'b0;
            reply_load     <= 1'b0;
            output_enabled <= 1'b0;
        end
        else
        begin
            fb.frame_end  <= rx.frame_end;
            pal.frame_end <= rx.frame_end;
            fb.valid      <= 1'b0;
            pal.valid     <= 1'b0;
            reply_load    <= 1'b0;

            if (rx.frame_end)
            begin
                opcode_ok     <= 1'b0;
                payload_first <= 1'b0;
            end
            else if (rx.valid && rx.first)
            begin
                opcode_ok     <= rx_op_known;
                payload_first <= 1'b1;
                if (rx_op_known)
                begin
                    case (rx_op)
                        OP_ENABLE      : output_enabled <= 1'b1;
                        OP_DISABLE     : output_enabled <= 1'b0;
                        OP_READ_STATUS : reply_load <= 1'b1;   // reply_tx counts the dummies
                        default        : ;
                    endcase
                end
            end
            else if (rx.valid && opcode_ok)
            begin
                payload_first <= 1'b0;
                fb.valid      <= opcode == OP_FB_WRITE;
                pal.valid     <= opcode == OP_PALETTE_SET;
                fb.first      <= payload_first;
                pal.first     <= payload_first;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        if (rx.valid && rx.first)
        begin
            opcode     <= rx_op;
            reply_byte <= status_now;   // status sampled when the command is decoded
        end
        if (rx.valid)
        begin
            fb.data  <= rx.data;
            pal.data <= rx.data;
        end
    end

endmodule

/* source/spi_nibble_rx.sv */
`timescale 1ns/1ns

module spi_nibble_rx
    import spi_gpu_pkg::*;
(
    input  logic          sclk,
    input  logic          reset,
    input  logic          cs_n,
    input  nibble_t       data_in,
    byte_stream_if.source bytes
);

    logic    phase;           // high once the upper nibble is held
    nibble_t hi_nib;
    logic    cs_n_q;
    logic    first_pending;   // no byte emitted yet in this transaction

    always_ff @(posedge sclk)
    begin
        if (reset)
        begin
            phase           <= 1'b0;
            cs_n_q          <= 1'b1;   // no frame_end straight out of reset
            first_pending   <= 1'b1;
            bytes.valid     <= 1'b0;
            bytes.first     <= 1'b0;
            bytes.frame_end <= 1'b0;
        end
        else
        begin
            cs_n_q          <= cs_n;
            bytes.frame_end <= cs_n && !cs_n_q;
            bytes.valid     <= 1'b0;

            if (cs_n)
            begin
                phase         <= 1'b0;
                first_pending <= 1'b1;
            end
            else if (!phase)
                phase <= 1'b1;
            else
            begin
                // second nibble of the pair, byte goes out next cycle
                phase         <= 1'b0;
                bytes.valid   <= 1'b1;
                bytes.first   <= first_pending;
                first_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        if (!cs_n && !phase)
            hi_nib <= data_in;   // msn first
        if (!cs_n && phase)
            bytes.data <= {hi_nib, data_in};
    end

endmodule

/* source/byte_stream_if.sv */
`timescale 1ns/1ns

// framed byte stream between pipeline stages, no back-pressure
interface byte_stream_if
    import spi_gpu_pkg::*;
();

    logic  valid;       // one cycle per byte
    byte_t data;
    logic  first;       // first byte of the transaction on this stream
    logic  frame_end;   // cs_n went high, drop partial state

    modport source
    (
        output valid,
        output data,
        output first,
        output frame_end
    );

    modport sink
    (
        input valid,
        input data,
        input first,
        input frame_end
    );

endinterface

/* source/spi_gpu_pkg.sv */
package spi_gpu_pkg;

`include "spi_gpu_settings.svh"

    typedef logic [3:0] nibble_t;   // one quad-spi bus word
    typedef logic [7:0] byte_t;

    typedef enum logic [7:0]
    {
        OP_FB_WRITE     = `SPI_GPU_OP_FB_WRITE,
        OP_PALETTE_SET  = `SPI_GPU_OP_PALETTE_SET,
        OP_READ_STATUS  = `SPI_GPU_OP_READ_STATUS,
        OP_ENABLE       = `SPI_GPU_OP_ENABLE,
        OP_DISABLE      = `SPI_GPU_OP_DISABLE
    } opcode_t;

    typedef logic [$clog2(`SPI_GPU_FB_PIXELS)-1:0] fb_addr_t;          // 17 bits
    typedef logic [7:0] pixel_t;                                       // palette index
    typedef logic [$clog2(`SPI_GPU_PALETTE_ENTRIES)-1:0] palette_addr_t;

    // red sits in the top byte since it is sent first
    typedef struct packed
    {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } palette_entry_t;

    typedef struct packed
    {
        logic [4:0] id;
        logic       hblank;
        logic       vblank;
        logic       output_enabled;
    } status_t;

endpackage

/* source/spi_gpu_settings.svh */
`ifndef SPI_GPU_SETTINGS_SVH
`define SPI_GPU_SETTINGS_SVH

// framebuffer is 320x240, one palette index per pixel
`define SPI_GPU_FB_PIXELS          76800

// pixel stream starts with a 24-bit start address, only the low 17 bits are kept
`define SPI_GPU_FB_ADDR_BYTES      3

`define SPI_GPU_PALETTE_ENTRIES    256   // 24-bit rgb entries

// nibble slots between the command byte and the first reply nibble
`define SPI_GPU_DUMMY_SLOTS        2

// top five bits of status register 0
`define SPI_GPU_STATUS_ID          5'b10110

// command codes
// bit 7 marks a command with payload, bit 6 one with a reply
`define SPI_GPU_OP_FB_WRITE        8'b1000_0010
`define SPI_GPU_OP_PALETTE_SET     8'b1000_0011
`define SPI_GPU_OP_READ_STATUS     8'b0100_0000
`define SPI_GPU_OP_ENABLE          8'b0000_0001
`define SPI_GPU_OP_DISABLE         8'b0000_0000

`endif
